// File: Bender.yml
package:
  name: rvcore

sources:
  - files:
      - design/rvCorePkg.sv
      - design/coreSequencer.sv
      - design/programCounter.sv
      - design/instrDecoder.sv
      - design/registerFile.sv
      - design/aluUnit.sv
      - design/dataMemory.sv
      - design/programMemory.sv
      - design/rvCoreTop.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/rvCoreTb.sv

// File: design/aluUnit.sv
`default_nettype none

module aluUnit import rvCorePkg::*; (
	input  aluOp_t op,
	input  word_t  a,
	input  word_t  b,
	output word_t  result,
	output logic   zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD:   result = a + b;
			ALU_SUB:   result = a - b;
			ALU_AND:   result = a & b;
			ALU_OR:    result = a | b;
			ALU_XOR:   result = a ^ b;
			ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:  result = {31'b0, a < b};
			ALU_SLL:   result = a << shamt;
			ALU_SRL:   result = a >> shamt;
			ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
			ALU_PASSB: result = b; // lui
			default:   result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/coreSequencer.sv
`default_nettype none

module coreSequencer import rvCorePkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic       haltReq,
	input  haltCause_t haltReason,
	output logic       fetchEn,
	output logic       execEn,
	output logic       halted,
	output haltCause_t haltCause
);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_EXEC, S_HALT} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			haltCause <= HALT_NONE;
		end else begin
			case (state)
				S_IDLE:  if (start) state <= S_FETCH;
				S_FETCH: state <= S_EXEC;
				S_EXEC: begin
					if (haltReq) begin
						state     <= S_HALT;
						haltCause <= haltReason; // held until reset
					end else begin
						state <= S_FETCH;
					end
				end
				default: state <= S_HALT; // terminal
			endcase
		end
	end

	assign fetchEn = (state == S_FETCH);
	assign execEn  = (state == S_EXEC);
	assign halted  = (state == S_HALT);

endmodule

`default_nettype wire

// File: design/dataMemory.sv
`default_nettype none

module dataMemory import rvCorePkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     we,
	input  memSize_t size,
	input  logic     unsignedLoad,
	input  word_t    addr,
	input  word_t    wdata,
	output word_t    rdata
);

	word_t                 mem [DATA_WORDS];
	logic [DATA_IDX_W-1:0] idx;
	logic [3:0]            laneMask;
	word_t                 laneData;
	word_t                 rawWord;
	word_t                 shifted;

	assign idx = addr[DATA_IDX_W+1:2]; // upper address bits ignored

	always_comb begin
		case (size)
			MEM_BYTE: begin
				laneMask = 4'b0001 << addr[1:0];
				laneData = {4{wdata[7:0]}};
			end
			MEM_HALF: begin
				laneMask = addr[1] ? 4'b1100 : 4'b0011;
				laneData = {2{wdata[15:0]}};
			end
			default: begin
				laneMask = 4'b1111;
				laneData = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DATA_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (laneMask[b]) mem[idx][b*8 +: 8] <= laneData[b*8 +: 8];
			end
		end
	end

	assign rawWord = mem[idx];
	assign shifted = rawWord >> {addr[1:0], 3'b000}; // selected lane to bit 0

	always_comb begin
		case (size)
			MEM_BYTE: rdata = {{24{shifted[7] & ~unsignedLoad}}, shifted[7:0]};
			MEM_HALF: rdata = {{16{shifted[15] & ~unsignedLoad}}, shifted[15:0]};
			default:  rdata = rawWord;
		endcase
	end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`default_nettype none

module instrDecoder import rvCorePkg::*; (
	input  word_t instr,
	output ctrl_t ctrl,
	output word_t imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// funct3 to alu op, alt picks sub/sra
	function automatic aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
		aluOp_t op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl       = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.wbSel = WB_ALU;
		ctrl.memSize = MEM_WORD;
		imm        = '0;
		case (opcode)
			OPC_LUI: begin
				imm            = {instr[31:12], 12'b0};
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = ALU_PASSB;
			end
			OPC_AUIPC: begin
				imm           = {instr[31:12], 12'b0};
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = WB_UPPER;
			end
			OPC_JAL: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = WB_PC4;
				ctrl.isJal    = 1'b1;
			end
			OPC_JALR: begin
				imm           = {{20{instr[31]}}, instr[31:20]};
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = WB_PC4;
				ctrl.isJalr   = 1'b1;
				ctrl.invalid  = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				ctrl.aluOp    = ALU_SUB; // beq compares via zero flag
				ctrl.isBranch = 1'b1;
				ctrl.invalid  = (funct3 != 3'b000); // only beq
			end
			OPC_LOAD: begin
				imm               = {{20{instr[31]}}, instr[31:20]};
				ctrl.regWrite     = 1'b1;
				ctrl.memRead      = 1'b1;
				ctrl.aluSrcImm    = 1'b1;
				ctrl.wbSel        = WB_LOAD;
				ctrl.memSize      = memSize_t'(funct3[1:0]);
				ctrl.loadUnsigned = funct3[2];
				ctrl.invalid      = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			end
			OPC_STORE: begin
				imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memSize   = memSize_t'(funct3[1:0]);
				ctrl.invalid   = (funct3[2] || funct3[1:0] == 2'b11);
			end
			OPC_OPIMM: begin
				imm            = {{20{instr[31]}}, instr[31:20]};
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluFromFunct3(funct3, 1'b0);
				ctrl.invalid   = (funct3 == 3'b001) || (funct3 == 3'b101); // no immediate shifts
			end
			OPC_OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluFromFunct3(funct3, funct7[5]);
				if (funct7 == 7'b0100000)
					ctrl.invalid = !(funct3 == 3'b000 || funct3 == 3'b101);
				else
					ctrl.invalid = (funct7 != 7'b0000000);
			end
			OPC_SYSTEM: begin
				ctrl.isEbreak = (instr == EBREAK_WORD);
				ctrl.invalid  = (instr != EBREAK_WORD);
			end
			default: ctrl.invalid = 1'b1;
		endcase

		// an unsupported word must not change any state
		if (ctrl.invalid) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memRead  = 1'b0;
			ctrl.isBranch = 1'b0;
			ctrl.isJal    = 1'b0;
			ctrl.isJalr   = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/programCounter.sv
`default_nettype none

module programCounter import rvCorePkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       execEn,
	input  nextPcSel_t sel,
	input  word_t      imm,
	input  word_t      jalrBase,
	output word_t      pc,
	output word_t      pcPlus4,
	output word_t      pcTarget
);

	word_t jalrTarget;
	word_t nextPc;

	assign pcPlus4    = pc + 32'd4;
	assign pcTarget   = pc + imm;  // branch, jal and auipc
	assign jalrTarget = (jalrBase + imm) & ~32'h1;

	always_comb begin
		case (sel)
			NPC_BRANCH, NPC_JAL: nextPc = pcTarget;
			NPC_JALR:            nextPc = jalrTarget;
			default:             nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (execEn) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: design/programMemory.sv
`default_nettype none

module programMemory import rvCorePkg::*; (
	input  logic      clk,
	input  progLoad_t load,
	input  logic      loadAllowed,
	input  logic      fetchEn,
	input  word_t     pc,
	output word_t     instr
);

	word_t mem [PROG_WORDS];

	always_ff @(posedge clk) begin
		if (load.en && loadAllowed) begin
			mem[load.index] <= load.data; // filled while core is idle or halted
		end
		if (fetchEn) begin
			instr <= mem[pc[PROG_IDX_W+1:2]]; // held through execute
		end
	end

endmodule

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile import rvCorePkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    we,
	input  regIdx_t rd,
	input  regIdx_t rs1,
	input  regIdx_t rs2,
	input  word_t   wdata,
	output word_t   rdata1,
	output word_t   rdata2
);

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;

	localparam word_t RESET_PC   = 32'h8000_0000;
	localparam int    PROG_WORDS = 64;
	localparam int    DATA_WORDS = 64;
	localparam int    PROG_IDX_W = $clog2(PROG_WORDS);
	localparam int    DATA_IDX_W = $clog2(DATA_WORDS);

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam word_t EBREAK_WORD = 32'h0010_0073; // only system word accepted

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
	} aluOp_t;

	// WB_UPPER is the pc-relative upper value of auipc
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_UPPER} wbSel_t;

	typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JAL, NPC_JALR} nextPcSel_t;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memSize_t;

	typedef enum logic [1:0] {HALT_NONE, HALT_EBREAK, HALT_INVALID} haltCause_t;

	typedef struct packed {
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     loadUnsigned;
		logic     aluSrcImm;
		aluOp_t   aluOp;
		wbSel_t   wbSel;
		logic     isBranch;
		logic     isJal;
		logic     isJalr;
		logic     isEbreak;
		logic     invalid;
	} ctrl_t;

	typedef struct packed {
		logic                  en;
		logic [PROG_IDX_W-1:0] index;
		word_t                 data;
	} progLoad_t;

	typedef struct packed {
		logic    valid;
		word_t   pc;
		regIdx_t rd;
		logic    regWrite;
		word_t   value;
	} retireTrace_t;

endpackage

`default_nettype wire

// File: design/rvCoreTop.sv
`default_nettype none

module rvCoreTop import rvCorePkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  progLoad_t    load,
	input  logic         start,
	output retireTrace_t trace,
	output logic         halted,
	output haltCause_t   haltCause
);

	logic       fetchEn, execEn;
	logic       haltReq;
	haltCause_t haltReason;
	word_t      instr, imm;
	ctrl_t      ctrl;
	word_t      pc, pcPlus4, pcTarget;
	nextPcSel_t npcSel;
	word_t      rdata1, rdata2;
	word_t      aluB, aluResult;
	logic       aluZero;
	word_t      loadData;
	word_t      wbValue;

	assign haltReq    = ctrl.isEbreak | ctrl.invalid;
	assign haltReason = ctrl.invalid ? HALT_INVALID : HALT_EBREAK;

	coreSequencer i_coreSequencer (
		.clk, .reset, .start, .haltReq, .haltReason,
		.fetchEn, .execEn, .halted, .haltCause
	);

	// load port only open while idle or halted
	programMemory i_programMemory (
		.clk, .load, .loadAllowed(!fetchEn && !execEn), .fetchEn, .pc, .instr
	);

	instrDecoder i_instrDecoder (.instr, .ctrl, .imm);

	always_comb begin
		if (ctrl.isJalr)                  npcSel = NPC_JALR;
		else if (ctrl.isJal)              npcSel = NPC_JAL;
		else if (ctrl.isBranch && aluZero) npcSel = NPC_BRANCH; // beq taken
		else                              npcSel = NPC_SEQ;
	end

	programCounter i_programCounter (
		.clk, .reset, .execEn, .sel(npcSel), .imm, .jalrBase(rdata1),
		.pc, .pcPlus4, .pcTarget
	);

	registerFile i_registerFile (
		.clk, .reset, .we(ctrl.regWrite && execEn),
		.rd(instr[11:7]), .rs1(instr[19:15]), .rs2(instr[24:20]),
		.wdata(wbValue), .rdata1, .rdata2
	);

	assign aluB = ctrl.aluSrcImm ? imm : rdata2;

	aluUnit i_aluUnit (.op(ctrl.aluOp), .a(rdata1), .b(aluB), .result(aluResult), .zero(aluZero));

	dataMemory i_dataMemory (
		.clk, .reset, .we(ctrl.memWrite && execEn), .size(ctrl.memSize),
		.unsignedLoad(ctrl.loadUnsigned), .addr(aluResult), .wdata(rdata2), .rdata(loadData)
	);

	always_comb begin
		case (ctrl.wbSel)
			WB_LOAD:  wbValue = ctrl.memRead ? loadData : '0;
			WB_PC4:   wbValue = pcPlus4;   // link address
			WB_UPPER: wbValue = pcTarget;  // auipc
			default:  wbValue = aluResult;
		endcase
	end

	always_comb begin
		trace.valid    = execEn; // one pulse per retired instruction
		trace.pc       = pc;
		trace.rd       = instr[11:7];
		trace.regWrite = ctrl.regWrite;
		trace.value    = wbValue;
	end

endmodule

`default_nettype wire

// File: sim/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef struct packed {
	word_t   instr;
	word_t   pc;       // expected retire pc, also picks the load slot
	regIdx_t rd;
	logic    regWrite;
	word_t   value;
} progRow_t;

localparam int         PROG_COUNT = 2;
localparam int         ROW_COUNT  = 38;
localparam int         PROG_LEN   [PROG_COUNT] = '{33, 5};
localparam haltCause_t PROG_CAUSE [PROG_COUNT] = '{HALT_EBREAK, HALT_INVALID};

// columns: instr, pc, rd, regWrite, value (value only matters when regWrite is set)
localparam progRow_t PROGRAM_ROWS [ROW_COUNT] = '{
	{32'h123450B7, 32'h80000000, 5'd1,  1'b1, 32'h12345000}, // lui x1
	{32'h00001117, 32'h80000004, 5'd2,  1'b1, 32'h80001004}, // auipc x2
	{32'hFFB00193, 32'h80000008, 5'd3,  1'b1, 32'hFFFFFFFB}, // addi x3, x0, -5
	{32'h00700213, 32'h8000000C, 5'd4,  1'b1, 32'h00000007},
	{32'h0041A2B3, 32'h80000010, 5'd5,  1'b1, 32'h00000001}, // slt, -5 < 7
	{32'h0041B333, 32'h80000014, 5'd6,  1'b1, 32'h00000000}, // sltu sees a huge value
	{32'h403203B3, 32'h80000018, 5'd7,  1'b1, 32'h0000000C}, // sub
	{32'h0F01C413, 32'h8000001C, 5'd8,  1'b1, 32'hFFFFFF0B}, // xori
	{32'h10026493, 32'h80000020, 5'd9,  1'b1, 32'h00000107}, // ori
	{32'h0FF1F513, 32'h80000024, 5'd10, 1'b1, 32'h000000FB}, // andi
	{32'hFFF1A593, 32'h80000028, 5'd11, 1'b1, 32'h00000001}, // slti
	{32'hFFF23613, 32'h8000002C, 5'd12, 1'b1, 32'h00000001}, // sltiu
	{32'h004216B3, 32'h80000030, 5'd13, 1'b1, 32'h00000380}, // sll
	{32'h4041D733, 32'h80000034, 5'd14, 1'b1, 32'hFFFFFFFF}, // sra
	{32'h0041D7B3, 32'h80000038, 5'd15, 1'b1, 32'h01FFFFFF}, // srl
	{32'h00420033, 32'h8000003C, 5'd0,  1'b1, 32'h0000000E}, // add x0 retires anyway
	{32'h00400833, 32'h80000040, 5'd16, 1'b1, 32'h00000007}, // x0 still reads zero
	{32'h0091F8B3, 32'h80000044, 5'd17, 1'b1, 32'h00000103}, // and
	{32'h04802023, 32'h80000048, 5'd0,  1'b0, 32'h00000000}, // sw x8, 64
	{32'h04901123, 32'h8000004C, 5'd2,  1'b0, 32'h00000000}, // sh x9, 66
	{32'h04A000A3, 32'h80000050, 5'd1,  1'b0, 32'h00000000}, // sb x10, 65
	{32'h04002903, 32'h80000054, 5'd18, 1'b1, 32'h0107FB0B}, // lw
	{32'h04001983, 32'h80000058, 5'd19, 1'b1, 32'hFFFFFB0B}, // lh
	{32'h04005A03, 32'h8000005C, 5'd20, 1'b1, 32'h0000FB0B}, // lhu
	{32'h04100A83, 32'h80000060, 5'd21, 1'b1, 32'hFFFFFFFB}, // lb
	{32'h04104B03, 32'h80000064, 5'd22, 1'b1, 32'h000000FB}, // lbu
	{32'h04201B83, 32'h80000068, 5'd23, 1'b1, 32'h00000107}, // lh, upper lane
	{32'h01020463, 32'h8000006C, 5'd8,  1'b0, 32'h00000000}, // beq taken
	{32'h00418463, 32'h80000074, 5'd8,  1'b0, 32'h00000000}, // beq not taken
	{32'h00C00C6F, 32'h80000078, 5'd24, 1'b1, 32'h8000007C}, // jal +12
	{32'h011C0CE7, 32'h80000084, 5'd25, 1'b1, 32'h80000088}, // jalr, odd target
	{32'h004C8D13, 32'h8000008C, 5'd26, 1'b1, 32'h8000008C},
	{32'h00100073, 32'h80000090, 5'd0,  1'b0, 32'h00000000}, // ebreak
	{32'h00300093, 32'h80000000, 5'd1,  1'b1, 32'h00000003}, // second program
	{32'h00108133, 32'h80000004, 5'd2,  1'b1, 32'h00000006},
	{32'h0020E1B3, 32'h80000008, 5'd3,  1'b1, 32'h00000007}, // or
	{32'h0011C233, 32'h8000000C, 5'd4,  1'b1, 32'h00000004}, // xor
	{32'h00209463, 32'h80000010, 5'd8,  1'b0, 32'h00000000}  // bne, not supported
};

`endif

// File: sim/rvCoreTb.sv
`default_nettype none

module rvCoreTb import rvCorePkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	`include "programTable.svh"

	localparam int WATCHDOG_CYCLES = 4 * ROW_COUNT + 200;

	logic         clk = 1'b0;
	logic         reset;
	progLoad_t    load;
	logic         start;
	retireTrace_t trace;
	logic         halted;
	haltCause_t   haltCause;

	rvCoreTop i_rvCoreTop (.clk, .reset, .load, .start, .trace, .halted, .haltCause);

	always #5 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	// value is compared only when a register is written
	task automatic checkTrace(input retireTrace_t expected);
		logic bad;
		bad = (trace.valid !== expected.valid);
		if (expected.valid) begin
			bad = bad || (trace.pc !== expected.pc) || (trace.rd !== expected.rd)
				|| (trace.regWrite !== expected.regWrite);
			if (expected.regWrite)
				bad = bad || (trace.value !== expected.value);
		end
		if (bad)
			abortRun($sformatf("MISMATCH at %0t: trace expected %p actual %p",
				$time, expected, trace));
	endtask

	task automatic checkHalt(input logic expected);
		if (halted !== expected)
			abortRun($sformatf("MISMATCH at %0t: halted expected %b actual %b",
				$time, expected, halted));
	endtask

	task automatic checkCause(input haltCause_t expected);
		if (haltCause !== expected)
			abortRun($sformatf("MISMATCH at %0t: haltCause expected %s actual %s (%b)",
				$time, expected.name(), haltCause.name(), haltCause));
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
	endtask

	// core must sit quiet while idle, then drive the load port
	task automatic idleCycle(input progLoad_t drive);
		@(negedge clk);
		checkTrace('0);
		checkHalt(1'b0);
		checkCause(HALT_NONE);
		load = drive;
	endtask

	task automatic loadProgram(input int first, input int count);
		progLoad_t word;
		word_t     offset;
		for (int i = first; i < first + count; i++) begin
			repeat ($urandom_range(2)) idleCycle('0); // random gap between writes
			offset     = PROGRAM_ROWS[i].pc - RESET_PC;
			word.en    = 1'b1;
			word.index = offset[PROG_IDX_W+1:2];
			word.data  = PROGRAM_ROWS[i].instr;
			idleCycle(word);
		end
		idleCycle('0);
	endtask

	// each instruction takes a fetch and an execute cycle
	task automatic runProgram(input int first, input int count, input haltCause_t cause);
		retireTrace_t expected;
		@(negedge clk);
		checkTrace('0);
		start = 1'b1;
		for (int i = first; i < first + count; i++) begin
			@(negedge clk);
			checkTrace('0); // fetch
			start = 1'b0;
			@(negedge clk);
			expected.valid    = 1'b1;
			expected.pc       = PROGRAM_ROWS[i].pc;
			expected.rd       = PROGRAM_ROWS[i].rd;
			expected.regWrite = PROGRAM_ROWS[i].regWrite;
			expected.value    = PROGRAM_ROWS[i].value;
			checkTrace(expected);
			checkHalt(1'b0); // halt only follows the last retire
			checkCause(HALT_NONE);
		end
		repeat (5) begin
			@(negedge clk);
			checkTrace('0); // no retire once halted
			checkHalt(1'b1);
			checkCause(cause);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abortRun($sformatf("timeout after %0d cycles, the core stopped retiring",
			WATCHDOG_CYCLES));
	end

	initial begin
		int first;
		void'($urandom(7));
		reset = 1'b1;
		start = 1'b0;
		load  = '0;
		first = 0;
		for (int p = 0; p < PROG_COUNT; p++) begin
			applyReset();
			loadProgram(first, PROG_LEN[p]);
			runProgram(first, PROG_LEN[p], PROG_CAUSE[p]);
			first += PROG_LEN[p];
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
design/rvCorePkg.sv
design/coreSequencer.sv
design/programCounter.sv
design/instrDecoder.sv
design/registerFile.sv
design/aluUnit.sv
design/dataMemory.sv
design/programMemory.sv
design/rvCoreTop.sv
sim/rvCoreTb.sv
